/* hdl/main_bus_pkg.sv */
// Shared constants for the main CPU bus glue
// Region indices of the programmable mapper, bus widths,
// key table geometry and the cabinet input word layout

`default_nettype none

package main_bus_pkg;

    // Mapper regions
    localparam int sel_w = 3;
    localparam logic [sel_w-1:0] reg_mem = 3'd0;
    localparam logic [sel_w-1:0] reg_scr = 3'd1;
    localparam logic [sel_w-1:0] reg_pal = 3'd2;
    localparam logic [sel_w-1:0] reg_obj = 3'd3;
    localparam logic [sel_w-1:0] reg_io  = 3'd4;
    localparam logic [sel_w-1:0] reg_sub = 3'd5;

    localparam int region_count = 6;

    // CPU word address runs from bit 23 down to bit 1
    localparam int addr_w = 23;
    localparam int data_w = 16;

    // Windows compare the top address byte
    localparam int win_w = 8;

    // Decryption key table, 8K bytes
    localparam int key_aw = 13;
    localparam int key_w  = 8;

    // Cabinet inputs
    localparam int joy_w = 8;
    localparam int dip_w = 8;
    localparam int btn_w = 2;

    // IO word select on addr bits 2:1
    localparam logic [1:0] io_joy1 = 2'd0;
    localparam logic [1:0] io_joy2 = 2'd1;
    localparam logic [1:0] io_dip  = 2'd2;
    localparam logic [1:0] io_sys  = 2'd3;

endpackage

`default_nettype wire

/* hdl/region_mapper.sv */
// Programmable address region mapper
// Six base/mask windows on the top address byte, first match wins,
// one-hot region output plus a flag for unmapped addresses

`timescale 1ns/1ns
`default_nettype none

module region_mapper
    import main_bus_pkg::*;
(
    input  wire                     clk,
    input  wire                     rst,
    input  wire  [addr_w:1]         addr,
    input  wire                     cfg_we,
    input  wire  [sel_w-1:0]        cfg_sel,
    input  wire  [win_w-1:0]        cfg_base,
    input  wire  [win_w-1:0]        cfg_mask,
    output logic [region_count-1:0] active,
    output logic                    none
);

    logic [win_w-1:0]        base_r [region_count];
    logic [win_w-1:0]        mask_r [region_count];
    logic [region_count-1:0] en_r;
    logic [region_count-1:0] hit;
    logic [win_w-1:0]        top;

    assign top = addr[addr_w:addr_w-win_w+1];

    // Window registers, all disabled out of reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < region_count; i++) begin
                base_r[i] <= '1;
                mask_r[i] <= '1;
            end
            en_r <= '0;
        end else if (cfg_we && cfg_sel < region_count) begin
            base_r[cfg_sel] <= cfg_base;
            mask_r[cfg_sel] <= cfg_mask;
            en_r[cfg_sel]   <= 1'b1;
        end
    end

    // Mask bits set to one take part in the compare
    always_comb begin
        for (int i = 0; i < region_count; i++) begin
            hit[i] = en_r[i] && (((top ^ base_r[i]) & mask_r[i]) == '0);
        end
    end

    // Lowest numbered window has priority
    always_comb begin
        active = '0;
        none   = 1'b1;
        for (int i = 0; i < region_count; i++) begin
            if (none && hit[i]) begin
                active[i] = 1'b1;
                none      = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/bus_ctrl.sv */
// Bus control block
// Registers the chip selects from the active region and the strobes,
// then answers the master with DTACK once the selected slave is ready

`timescale 1ns/1ns
`default_nettype none

module bus_ctrl
    import main_bus_pkg::*;
(
    input  wire                     clk,
    input  wire                     rst,
    input  wire  [addr_w:1]         addr,
    input  wire                     asn,
    input  wire                     rnw,
    input  wire  [1:0]              dsn,
    input  wire  [region_count-1:0] active,
    input  wire                     none,
    input  wire                     ram_ok,
    input  wire                     dec_ok,
    output logic                    rom_cs,
    output logic                    ram_cs,
    output logic                    vram_cs,
    output logic                    char_cs,
    output logic                    pal_cs,
    output logic                    objram_cs,
    output logic                    io_cs,
    output logic                    sub_cs,
    output logic                    none_cs,
    output logic                    dtackn
);

    logic ds_low;
    logic strobe_ok;
    logic mem_ram;
    logic scr_char;
    logic ready;

    assign ds_low    = ~&dsn;
    // Writes wait for a data strobe, reads only need AS
    assign strobe_ok = !asn && (ds_low || rnw);
    // Top quarter of the memory region is work RAM
    assign mem_ram   = addr[18:17] == 2'b11;
    assign scr_char  = addr[16];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_cs    <= 1'b0;
            ram_cs    <= 1'b0;
            vram_cs   <= 1'b0;
            char_cs   <= 1'b0;
            pal_cs    <= 1'b0;
            objram_cs <= 1'b0;
            io_cs     <= 1'b0;
            sub_cs    <= 1'b0;
            none_cs   <= 1'b0;
        end else if (strobe_ok) begin
            rom_cs    <= active[reg_mem] && !mem_ram;
            ram_cs    <= active[reg_mem] && mem_ram && ds_low;
            char_cs   <= active[reg_scr] && scr_char;
            vram_cs   <= active[reg_scr] && !scr_char && ds_low;
            pal_cs    <= active[reg_pal];
            objram_cs <= active[reg_obj];
            io_cs     <= active[reg_io];
            sub_cs    <= active[reg_sub];
            none_cs   <= none;
        end else begin
            rom_cs    <= 1'b0;
            ram_cs    <= 1'b0;
            vram_cs   <= 1'b0;
            char_cs   <= 1'b0;
            pal_cs    <= 1'b0;
            objram_cs <= 1'b0;
            io_cs     <= 1'b0;
            sub_cs    <= 1'b0;
            none_cs   <= 1'b0;
        end
    end

    // Internal slaves answer as soon as they are selected
    assign ready = ((ram_cs || vram_cs) && ram_ok)
                 || (rom_cs && dec_ok)
                 || char_cs || pal_cs || objram_cs
                 || io_cs || sub_cs || none_cs;

    // DTACK holds low until the master releases AS
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dtackn <= 1'b1;
        end else if (asn) begin
            dtackn <= 1'b1;
        end else if (ready) begin
            dtackn <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hdl/rom_decoder.sv */
// Program ROM decryption
// Loadable 8K byte key table and the XOR of ROM words with the key byte,
// registered together with a delayed ROM ok

`timescale 1ns/1ns
`default_nettype none

module rom_decoder
    import main_bus_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst,
    input  wire  [key_aw-1:0]   prog_addr,
    input  wire                 key_we,
    input  wire  [key_w-1:0]    prog_data,
    input  wire                 dec_en,
    input  wire                 fc_op,
    input  wire  [addr_w:1]     addr,
    input  wire                 rom_cs,
    input  wire  [data_w-1:0]   rom_data,
    input  wire                 rom_ok,
    output logic [data_w-1:0]   dec,
    output logic                dec_ok
);

    logic [key_w-1:0]  key_mem [2**key_aw];
    logic [key_w-1:0]  key_q;
    logic [data_w-1:0] xor_word;

    // Key table write port and registered lookup
    // The address is stable long before the ROM answers
    always_ff @(posedge clk) begin
        if (key_we) begin
            key_mem[prog_addr] <= prog_data;
        end
        key_q <= key_mem[addr[key_aw:1]];
    end

    // Opcodes use the key in both bytes, data only in the low byte
    always_comb begin
        if (!dec_en) begin
            xor_word = '0;
        end else if (fc_op) begin
            xor_word = {key_q, key_q};
        end else begin
            xor_word = {{(data_w-key_w){1'b0}}, key_q};
        end
    end

    always_ff @(posedge clk) begin
        if (rom_cs && rom_ok) begin
            dec <= rom_data ^ xor_word;
        end
    end

    // ok trails the ROM by one cycle, lined up with dec
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dec_ok <= 1'b0;
        end else begin
            dec_ok <= rom_cs && rom_ok;
        end
    end

endmodule

`default_nettype wire

/* hdl/read_mux.sv */
// CPU read data multiplexer
// Registered selection between memories, video and cabinet inputs

`timescale 1ns/1ns
`default_nettype none

module read_mux
    import main_bus_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 ram_cs,
    input  wire                 vram_cs,
    input  wire                 rom_cs,
    input  wire                 char_cs,
    input  wire                 pal_cs,
    input  wire                 objram_cs,
    input  wire                 io_cs,
    input  wire                 none_cs,
    input  wire  [data_w-1:0]   ram_data,
    input  wire  [data_w-1:0]   dec,
    input  wire  [data_w-1:0]   char_dout,
    input  wire  [data_w-1:0]   pal_dout,
    input  wire  [data_w-1:0]   obj_dout,
    input  wire  [addr_w:1]     addr,
    input  wire  [joy_w-1:0]    joystick1,
    input  wire  [joy_w-1:0]    joystick2,
    input  wire  [dip_w-1:0]    dipsw_a,
    input  wire  [dip_w-1:0]    dipsw_b,
    input  wire  [btn_w-1:0]    start_button,
    input  wire  [btn_w-1:0]    coin_input,
    input  wire                 service,
    output logic [data_w-1:0]   rdata
);

    logic [data_w-1:0] cab_dout;

    // Unused cabinet bits read as ones
    always_comb begin
        case (addr[2:1])
            io_joy1: cab_dout = {{(data_w-joy_w){1'b1}}, joystick1};
            io_joy2: cab_dout = {{(data_w-joy_w){1'b1}}, joystick2};
            io_dip:  cab_dout = {dipsw_b, dipsw_a};
            io_sys:  cab_dout = {{(data_w-1-2*btn_w){1'b1}}, service,
                                 start_button, coin_input};
            default: cab_dout = '1;
        endcase
    end

    // Open bus for none_cs and for no select
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdata <= '1;
        end else begin
            rdata <= (ram_cs || vram_cs) ? ram_data  :
                     rom_cs              ? dec       :
                     char_cs             ? char_dout :
                     pal_cs              ? pal_dout  :
                     objram_cs           ? obj_dout  :
                     io_cs               ? cab_dout  :
                                           '1;
        end
    end

endmodule

`default_nettype wire

/* hdl/main_bus.sv */
// Main CPU bus glue, top level
// Region mapper, bus control, ROM decryption and read multiplexer
// behind a plain 68000 style bus master port

`timescale 1ns/1ns
`default_nettype none

module main_bus
    import main_bus_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst,

    // Bus master
    input  wire  [addr_w:1]     addr,
    input  wire                 asn,
    input  wire                 rnw,
    input  wire  [1:0]          dsn,
    input  wire  [data_w-1:0]   wdata,
    input  wire                 fc_op,
    output logic [data_w-1:0]   rdata,
    output logic                dtackn,

    // Mapper and key table setup
    input  wire                 cfg_we,
    input  wire  [sel_w-1:0]    cfg_sel,
    input  wire  [win_w-1:0]    cfg_base,
    input  wire  [win_w-1:0]    cfg_mask,
    input  wire                 key_we,
    input  wire  [key_aw-1:0]   prog_addr,
    input  wire  [key_w-1:0]    prog_data,
    input  wire                 dec_en,

    // Shared memory bus
    output logic [19:1]         mem_addr,
    output logic [data_w-1:0]   mem_wdata,
    output logic [1:0]          mem_dsn,
    output logic                mem_rnw,

    // ROM and RAM
    output logic [19:1]         rom_addr,
    output logic                rom_cs,
    input  wire  [data_w-1:0]   rom_data,
    input  wire                 rom_ok,
    output logic                ram_cs,
    output logic                vram_cs,
    input  wire  [data_w-1:0]   ram_data,
    input  wire                 ram_ok,

    // Video and sub CPU
    output logic                char_cs,
    output logic                pal_cs,
    output logic                objram_cs,
    output logic                sub_cs,
    input  wire  [data_w-1:0]   char_dout,
    input  wire  [data_w-1:0]   pal_dout,
    input  wire  [data_w-1:0]   obj_dout,

    // Cabinet
    input  wire  [joy_w-1:0]    joystick1,
    input  wire  [joy_w-1:0]    joystick2,
    input  wire  [dip_w-1:0]    dipsw_a,
    input  wire  [dip_w-1:0]    dipsw_b,
    input  wire  [btn_w-1:0]    start_button,
    input  wire  [btn_w-1:0]    coin_input,
    input  wire                 service
);

    logic [region_count-1:0] active;
    logic                    none;
    logic                    io_cs;
    logic                    none_cs;
    logic [data_w-1:0]       dec;
    logic                    dec_ok;

    assign mem_addr  = addr[19:1];
    assign rom_addr  = addr[19:1];
    assign mem_wdata = wdata;
    assign mem_dsn   = dsn;
    assign mem_rnw   = rnw;

    region_mapper u_mapper (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .addr       ( addr       ),
        .cfg_we     ( cfg_we     ),
        .cfg_sel    ( cfg_sel    ),
        .cfg_base   ( cfg_base   ),
        .cfg_mask   ( cfg_mask   ),
        .active     ( active     ),
        .none       ( none       )
    );

    bus_ctrl u_ctrl (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .addr       ( addr       ),
        .asn        ( asn        ),
        .rnw        ( rnw        ),
        .dsn        ( dsn        ),
        .active     ( active     ),
        .none       ( none       ),
        .ram_ok     ( ram_ok     ),
        .dec_ok     ( dec_ok     ),
        .rom_cs     ( rom_cs     ),
        .ram_cs     ( ram_cs     ),
        .vram_cs    ( vram_cs    ),
        .char_cs    ( char_cs    ),
        .pal_cs     ( pal_cs     ),
        .objram_cs  ( objram_cs  ),
        .io_cs      ( io_cs      ),
        .sub_cs     ( sub_cs     ),
        .none_cs    ( none_cs    ),
        .dtackn     ( dtackn     )
    );

    rom_decoder u_dec (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .prog_addr  ( prog_addr  ),
        .key_we     ( key_we     ),
        .prog_data  ( prog_data  ),
        .dec_en     ( dec_en     ),
        .fc_op      ( fc_op      ),
        .addr       ( addr       ),
        .rom_cs     ( rom_cs     ),
        .rom_data   ( rom_data   ),
        .rom_ok     ( rom_ok     ),
        .dec        ( dec        ),
        .dec_ok     ( dec_ok     )
    );

    read_mux u_rmux (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .ram_cs       ( ram_cs       ),
        .vram_cs      ( vram_cs      ),
        .rom_cs       ( rom_cs       ),
        .char_cs      ( char_cs      ),
        .pal_cs       ( pal_cs       ),
        .objram_cs    ( objram_cs    ),
        .io_cs        ( io_cs        ),
        .none_cs      ( none_cs      ),
        .ram_data     ( ram_data     ),
        .dec          ( dec          ),
        .char_dout    ( char_dout    ),
        .pal_dout     ( pal_dout     ),
        .obj_dout     ( obj_dout     ),
        .addr         ( addr         ),
        .joystick1    ( joystick1    ),
        .joystick2    ( joystick2    ),
        .dipsw_a      ( dipsw_a      ),
        .dipsw_b      ( dipsw_b      ),
        .start_button ( start_button ),
        .coin_input   ( coin_input   ),
        .service      ( service      ),
        .rdata        ( rdata        )
    );

endmodule

`default_nettype wire

/* testbench/main_bus_tb.sv */
// Testbench for the main CPU bus glue
// Clock and reset, RAM and ROM models with a random ok delay,
// a table-driven bus master and the response checks

`timescale 1ns/1ns
`default_nettype none

module main_bus_tb
    import main_bus_pkg::*;
();

    localparam int unsigned seed = 32'h385c_5dd3;

    // Row operations
    localparam logic [2:0] op_cfg = 3'd0;
    localparam logic [2:0] op_key = 3'd1;
    localparam logic [2:0] op_rd  = 3'd2;
    localparam logic [2:0] op_ram = 3'd3;
    localparam logic [2:0] op_rom = 3'd4;
    localparam logic [2:0] op_wr  = 3'd5;
    localparam logic [2:0] op_vrd = 3'd6;

    // Video and cabinet sources
    localparam logic [15:0] char_val    = 16'h3c3c;
    localparam logic [15:0] pal_val     = 16'h5a01;
    localparam logic [15:0] obj_val     = 16'h0b7e;
    localparam logic [7:0]  joy1_val    = 8'hfe;
    localparam logic [7:0]  joy2_val    = 8'hbd;
    localparam logic [7:0]  dipa_val    = 8'h12;
    localparam logic [7:0]  dipb_val    = 8'hef;
    localparam logic [1:0]  start_val   = 2'b10;
    localparam logic [1:0]  coin_val    = 2'b01;
    localparam logic        service_val = 1'b0;

    // Key bytes for the three decrypted ROM addresses
    localparam logic [7:0] key0 = 8'h9c;
    localparam logic [7:0] key1 = 8'h47;
    localparam logic [7:0] key2 = 8'he1;

    // Only read that lands in the sub CPU window
    localparam logic [31:0] sub_addr = 32'h500000;

    typedef struct packed {
        logic [2:0]  op;
        logic [31:0] addr;
        logic [15:0] data;
        logic [1:0]  dsn;
        logic        fc;
        logic        de;
        logic [15:0] exp;
    } row_t;

    logic              clk;
    logic              rst;
    logic [addr_w:1]   addr;
    logic              asn;
    logic              rnw;
    logic [1:0]        dsn;
    logic [data_w-1:0] wdata;
    logic              fc_op;
    logic [data_w-1:0] rdata;
    logic              dtackn;
    logic              cfg_we;
    logic [sel_w-1:0]  cfg_sel;
    logic [win_w-1:0]  cfg_base;
    logic [win_w-1:0]  cfg_mask;
    logic              key_we;
    logic [key_aw-1:0] prog_addr;
    logic [key_w-1:0]  prog_data;
    logic              dec_en;
    logic [19:1]       mem_addr;
    logic [data_w-1:0] mem_wdata;
    logic [1:0]        mem_dsn;
    logic              mem_rnw;
    logic [19:1]       rom_addr;
    logic              rom_cs;
    logic [data_w-1:0] rom_data;
    logic              rom_ok;
    logic              ram_cs;
    logic              vram_cs;
    logic [data_w-1:0] ram_data;
    logic              ram_ok;
    logic              char_cs;
    logic              pal_cs;
    logic              objram_cs;
    logic              sub_cs;

    row_t        rows[$];
    int unsigned ram_delay;
    int unsigned rom_delay;
    int unsigned ram_cnt;
    int unsigned rom_cnt;
    int unsigned cycles;
    int unsigned limit;
    int unsigned checks;
    int unsigned errors;

    main_bus main_bus_i (
        .clk(clk), .rst(rst),
        .addr(addr), .asn(asn), .rnw(rnw), .dsn(dsn), .wdata(wdata), .fc_op(fc_op),
        .rdata(rdata), .dtackn(dtackn),
        .cfg_we(cfg_we), .cfg_sel(cfg_sel), .cfg_base(cfg_base), .cfg_mask(cfg_mask),
        .key_we(key_we), .prog_addr(prog_addr), .prog_data(prog_data), .dec_en(dec_en),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_dsn(mem_dsn), .mem_rnw(mem_rnw),
        .rom_addr(rom_addr), .rom_cs(rom_cs), .rom_data(rom_data), .rom_ok(rom_ok),
        .ram_cs(ram_cs), .vram_cs(vram_cs), .ram_data(ram_data), .ram_ok(ram_ok),
        .char_cs(char_cs), .pal_cs(pal_cs), .objram_cs(objram_cs), .sub_cs(sub_cs),
        .char_dout(char_val), .pal_dout(pal_val), .obj_dout(obj_val),
        .joystick1(joy1_val), .joystick2(joy2_val), .dipsw_a(dipa_val), .dipsw_b(dipb_val),
        .start_button(start_val), .coin_input(coin_val), .service(service_val)
    );

    // Memory contents as fixed functions of the byte address
    function automatic logic [15:0] ram_word(input logic [31:0] a);
        return a[16:1] ^ 16'ha55a;
    endfunction

    function automatic logic [15:0] rom_word(input logic [31:0] a);
        return {a[8:1], a[16:9]} ^ 16'h1234;
    endfunction

    function automatic logic [31:0] key_index(input logic [31:0] a);
        return {19'd0, a[13:1]};
    endfunction

    assign ram_data = ram_word({12'd0, mem_addr, 1'b0});
    assign rom_data = rom_word({12'd0, rom_addr, 1'b0});

    always #50 clk = ~clk;

    // RAM and ROM answer after their drawn delay while selected
    always @(posedge clk) begin
        #10;
        if (ram_cs || vram_cs) begin
            if (ram_cnt >= ram_delay) begin
                ram_ok = 1'b1;
            end else begin
                ram_cnt++;
            end
        end else begin
            ram_cnt = 0;
            ram_ok  = 1'b0;
        end
        if (rom_cs) begin
            if (rom_cnt >= rom_delay) begin
                rom_ok = 1'b1;
            end else begin
                rom_cnt++;
            end
        end else begin
            rom_cnt = 0;
            rom_ok  = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: run exceeded %0d clock cycles", limit);
            $display("tests failed");
            $finish;
        end
    end

    task automatic add_row(input logic [2:0] op, input logic [31:0] a,
                           input logic [15:0] d, input logic [1:0] ds,
                           input logic fc, input logic de, input logic [15:0] e);
        row_t r;
        r.op   = op;
        r.addr = a;
        r.data = d;
        r.dsn  = ds;
        r.fc   = fc;
        r.de   = de;
        r.exp  = e;
        rows.push_back(r);
    endtask

    task automatic build_table();
        // Window rows carry the base in the high byte and the mask in the low byte
        // The sub window also covers the io range
        add_row(op_cfg, 32'(reg_mem), {8'h00, 8'hf0}, 2'b11, 0, 0, 0);
        add_row(op_cfg, 32'(reg_scr), {8'h10, 8'hfe}, 2'b11, 0, 0, 0);
        add_row(op_cfg, 32'(reg_pal), {8'h20, 8'hff}, 2'b11, 0, 0, 0);
        add_row(op_cfg, 32'(reg_obj), {8'h30, 8'hff}, 2'b11, 0, 0, 0);
        add_row(op_cfg, 32'(reg_io),  {8'h40, 8'hff}, 2'b11, 0, 0, 0);
        add_row(op_cfg, 32'(reg_sub), {8'h50, 8'he0}, 2'b11, 0, 0, 0);
        add_row(op_key, key_index(32'h000100), {8'h00, key0}, 2'b11, 0, 0, 0);
        add_row(op_key, key_index(32'h002468), {8'h00, key1}, 2'b11, 0, 0, 0);
        add_row(op_key, key_index(32'h05fffe), {8'h00, key2}, 2'b11, 0, 0, 0);
        add_row(op_rom, 32'h000100, 0, 2'b00, 1, 0, rom_word(32'h000100));
        add_row(op_rom, 32'h000100, 0, 2'b00, 1, 1, rom_word(32'h000100) ^ {key0, key0});
        add_row(op_rom, 32'h002468, 0, 2'b00, 0, 1, rom_word(32'h002468) ^ {8'h00, key1});
        add_row(op_rom, 32'h05fffe, 0, 2'b00, 1, 1, rom_word(32'h05fffe) ^ {key2, key2});
        add_row(op_ram, 32'h060010, 0, 2'b00, 0, 0, ram_word(32'h060010));
        add_row(op_ram, 32'h07fffe, 0, 2'b00, 0, 0, ram_word(32'h07fffe));
        add_row(op_wr,  32'h060020, 16'hbeef, 2'b00, 0, 0, 0);
        add_row(op_wr,  32'h060022, 16'h1357, 2'b10, 0, 0, 0);
        add_row(op_rd,  32'h110040, 0, 2'b00, 0, 0, char_val);
        add_row(op_vrd, 32'h100080, 0, 2'b00, 0, 0, ram_word(32'h100080));
        add_row(op_rd,  32'h200002, 0, 2'b00, 0, 0, pal_val);
        add_row(op_rd,  32'h300004, 0, 2'b00, 0, 0, obj_val);
        add_row(op_rd,  32'h400000, 0, 2'b00, 0, 0, {8'hff, joy1_val});
        add_row(op_rd,  32'h400002, 0, 2'b00, 0, 0, {8'hff, joy2_val});
        add_row(op_rd,  32'h400004, 0, 2'b00, 0, 0, {dipb_val, dipa_val});
        add_row(op_rd,  32'h400006, 0, 2'b00, 0, 0,
                {11'h7ff, service_val, start_val, coin_val});
        add_row(op_rd,  sub_addr, 0, 2'b00, 0, 0, 16'hffff);
        add_row(op_rd,  32'h800000, 0, 2'b00, 0, 0, 16'hffff);
    endtask

    task automatic check_idle(input string where);
        checks++;
        if ({rom_cs, ram_cs, vram_cs, char_cs, pal_cs, objram_cs, sub_cs} !== 7'd0
                || dtackn !== 1'b1) begin
            errors++;
            $display("MISMATCH at %0t: selects or dtackn still active %s", $time, where);
        end
    endtask

    task automatic bus_cycle(input row_t r);
        int unsigned lat;
        int unsigned want;
        ram_delay = $urandom % 5;
        rom_delay = $urandom % 5;
        addr  = r.addr[23:1];
        fc_op = r.fc;
        dec_en = r.de;
        wdata = r.data;
        rnw   = (r.op != op_wr);
        dsn   = (r.op == op_vrd) ? 2'b11 : r.dsn;
        asn   = 1'b0;
        // Address strobe alone must not open the vram half
        if (r.op == op_vrd) begin
            repeat (3) begin
                @(posedge clk);
                #10;
                checks++;
                if (vram_cs !== 1'b0 || dtackn !== 1'b1) begin
                    errors++;
                    $display("MISMATCH at %0t: vram_cs %b dtackn %b without data strobe",
                             $time, vram_cs, dtackn);
                end
            end
            dsn = 2'b00;
        end
        lat = 0;
        do begin
            @(posedge clk);
            #10;
            lat++;
        end while (dtackn !== 1'b0);
        // RAM and vram cycles wait on ram_ok
        case (r.op)
            op_rd:   want = 2;
            op_rom:  want = 3 + rom_delay;
            default: want = 2 + ram_delay;
        endcase
        checks++;
        if (lat != want) begin
            errors++;
            $display("MISMATCH at %0t: dtackn after %0d cycles, expected %0d at %h",
                     $time, lat, want, r.addr);
        end
        checks++;
        if (sub_cs !== (r.addr == sub_addr)) begin
            errors++;
            $display("MISMATCH at %0t: sub_cs %b at %h", $time, sub_cs, r.addr);
        end
        checks++;
        if (r.op == op_wr) begin
            if (ram_cs !== 1'b1 || mem_wdata !== r.data || mem_dsn !== r.dsn
                    || mem_rnw !== 1'b0) begin
                errors++;
                $display("MISMATCH at %0t: write cs %b data %h dsn %b rnw %b",
                         $time, ram_cs, mem_wdata, mem_dsn, mem_rnw);
            end
        end else if (rdata !== r.exp) begin
            errors++;
            $display("MISMATCH at %0t: read %h got %h expected %h",
                     $time, r.addr, rdata, r.exp);
        end
        asn = 1'b1;
        dsn = 2'b11;
        rnw = 1'b1;
        @(posedge clk);
        #10;
        check_idle("after AS rise");
    endtask

    task automatic run_row(input row_t r);
        case (r.op)
            op_cfg: begin
                cfg_we   = 1'b1;
                cfg_sel  = r.addr[2:0];
                cfg_base = r.data[15:8];
                cfg_mask = r.data[7:0];
                @(posedge clk);
                #10;
                cfg_we = 1'b0;
            end
            op_key: begin
                key_we    = 1'b1;
                prog_addr = r.addr[12:0];
                prog_data = r.data[7:0];
                @(posedge clk);
                #10;
                key_we = 1'b0;
            end
            default: bus_cycle(r);
        endcase
    endtask

    initial begin
        void'($urandom(seed));
        clk = 1'b0;
        rst = 1'b1;
        addr = '0;
        asn = 1'b1;
        rnw = 1'b1;
        dsn = 2'b11;
        wdata = '0;
        fc_op = 1'b0;
        cfg_we = 1'b0;
        cfg_sel = '0;
        cfg_base = '0;
        cfg_mask = '0;
        key_we = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        dec_en = 1'b0;
        ram_ok = 1'b0;
        rom_ok = 1'b0;
        ram_cnt = 0;
        rom_cnt = 0;
        ram_delay = 0;
        rom_delay = 0;
        cycles = 0;
        checks = 0;
        errors = 0;
        build_table();
        // Reset counts as one more row
        limit = 40 * (rows.size() + 1);
        repeat (3) @(posedge clk);
        #10;
        rst = 1'b0;
        check_idle("after reset");
        foreach (rows[i]) begin
            run_row(rows[i]);
        end
        $display("rows: %0d  checks: %0d  errors: %0d", rows.size(), checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* main_bus.f */
hdl/main_bus_pkg.sv
hdl/region_mapper.sv
hdl/bus_ctrl.sv
hdl/rom_decoder.sv
hdl/read_mux.sv
hdl/main_bus.sv
testbench/main_bus_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module main_bus_tb \
    -Mdir obj_dir -f main_bus.f
./obj_dir/Vmain_bus_tb > sim.log 2>&1
cat sim.log

if grep -q "^all tests passed$" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
